// ==== rtl/engine_pkg.sv ====
`default_nettype none

package engine_pkg;

   // fixed slot map of the data bus
   localparam int n_slots = 4;

   // select codes of n_slots and above mean no operand
   localparam int sel_w = 3;

   localparam int slot_in_a   = 0;
   localparam int slot_in_b   = 1;
   localparam int slot_alu    = 2;
   localparam int slot_muladd = 3;

   // configuration addresses
   localparam logic cfg_addr_alu    = 1'b0;
   localparam logic cfg_addr_muladd = 1'b1;

   // max and min compare signed
   typedef enum logic [2:0] {
      alu_add    = 3'd0,
      alu_sub    = 3'd1,
      alu_and    = 3'd2,
      alu_or     = 3'd3,
      alu_xor    = 3'd4,
      alu_max    = 3'd5,
      alu_min    = 3'd6,
      alu_pass_a = 3'd7
   } alu_op_e;

   typedef enum logic [1:0] {
      mop_mul      = 2'd0,
      mop_macc     = 2'd1,
      mop_msub     = 2'd2,
      mop_macc_q16 = 2'd3
   } muladd_op_e;

   typedef struct packed {
      logic [sel_w-1:0] sela;
      logic [sel_w-1:0] selb;
      alu_op_e          op;
   } alu_cfg_t;

   // selo picks the reload operand
   typedef struct packed {
      logic [sel_w-1:0] sela;
      logic [sel_w-1:0] selb;
      logic [sel_w-1:0] selo;
      muladd_op_e       op;
   } muladd_cfg_t;

endpackage

`default_nettype wire

// ==== rtl/operand_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_select #(
   parameter int data_w = 32
) (
   input  logic [engine_pkg::sel_w-1:0]                 sel,
   input  logic [engine_pkg::n_slots-1:0][data_w-1:0]   bus,
   output logic [data_w-1:0]                            operand,
   output logic                                         present
);

   localparam int idx_w = $clog2(engine_pkg::n_slots);

   logic [idx_w-1:0] idx;

   assign idx = sel[idx_w-1:0];

   // codes past the last slot select nothing
   always_comb begin
      present = (sel < engine_pkg::sel_w'(engine_pkg::n_slots));
      if (present) begin
         operand = bus[idx];
      end else begin
         operand = '0;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mul_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_pipe #(
   parameter int data_w = 32
) (
   input  logic                       clk,
   input  logic                       rst_reg,
   input  logic                       advance,
   input  logic                       clear,
   input  logic signed [data_w-1:0]   op_a,
   input  logic signed [data_w-1:0]   op_b,
   output logic signed [2*data_w-1:0] product
);

   // stage 1 operands
   logic signed [data_w-1:0] a_r;
   logic signed [data_w-1:0] b_r;

   always_ff @(posedge clk) begin
      if (rst_reg || clear) begin
         a_r     <= '0;
         b_r     <= '0;
         product <= '0;
      end else if (advance) begin
         a_r     <= op_a;
         b_r     <= op_b;
         // stage 2 multiplies what stage 1 held
         product <= a_r * b_r;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/muladd_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module muladd_unit #(
   parameter int data_w = 32
) (
   input  logic                                       clk,
   input  logic                                       rst_reg,
   input  logic                                       step_en,
   input  logic                                       clear,
   input  engine_pkg::muladd_cfg_t                    cfg,
   input  logic [engine_pkg::n_slots-1:0][data_w-1:0] bus,
   output logic [data_w-1:0]                          result
);

   logic [data_w-1:0] op_a;
   logic [data_w-1:0] op_b;
   logic [data_w-1:0] op_o;
   logic              present_a;
   logic              present_b;
   logic              present_o;
   logic              advance;

   logic signed [2*data_w-1:0] product;
   logic [data_w-1:0]          q16_mid;
   logic [2*data_w-1:0]        q16_term;
   logic [2*data_w-1:0]        acc;
   logic [2*data_w-1:0]        acc_next;

   // reload flag travels beside the product
   logic reload_d1;
   logic reload_d2;

   operand_select #(.data_w(data_w)) u_sel_a (
      .sel     (cfg.sela),
      .bus     (bus),
      .operand (op_a),
      .present (present_a)
   );

   operand_select #(.data_w(data_w)) u_sel_b (
      .sel     (cfg.selb),
      .bus     (bus),
      .operand (op_b),
      .present (present_b)
   );

   operand_select #(.data_w(data_w)) u_sel_o (
      .sel     (cfg.selo),
      .bus     (bus),
      .operand (op_o),
      .present (present_o)
   );

   // a missing operand holds the whole unit
   assign advance = step_en && present_a && present_b && present_o;

   mul_pipe #(.data_w(data_w)) u_mul_pipe (
      .clk     (clk),
      .rst_reg (rst_reg),
      .advance (advance),
      .clear   (clear),
      .op_a    ($signed(op_a)),
      .op_b    ($signed(op_b)),
      .product (product)
   );

   // q16 middle word, sign extended
   assign q16_mid  = product[data_w/2 +: data_w];
   assign q16_term = {{data_w{q16_mid[data_w-1]}}, q16_mid};

   always_comb begin
      case (cfg.op)
         engine_pkg::mop_mul: begin
            acc_next = product;
         end
         engine_pkg::mop_macc: begin
            acc_next = reload_d2 ? product : acc + product;
         end
         // reload takes the product itself, not its negation
         engine_pkg::mop_msub: begin
            acc_next = reload_d2 ? product : acc - product;
         end
         engine_pkg::mop_macc_q16: begin
            acc_next = reload_d2 ? q16_term : acc + q16_term;
         end
         default: begin
            acc_next = product;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_reg || clear) begin
         acc       <= '0;
         reload_d1 <= 1'b0;
         reload_d2 <= 1'b0;
      end else if (advance) begin
         acc       <= acc_next;
         reload_d1 <= (op_o == '0);
         reload_d2 <= reload_d1;
      end
   end

   assign result = acc[data_w-1:0];

endmodule

`default_nettype wire

// ==== rtl/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_unit #(
   parameter int data_w = 32
) (
   input  logic                                       clk,
   input  logic                                       rst_reg,
   input  logic                                       step_en,
   input  logic                                       clear,
   input  engine_pkg::alu_cfg_t                       cfg,
   input  logic [engine_pkg::n_slots-1:0][data_w-1:0] bus,
   output logic [data_w-1:0]                          result
);

   logic [data_w-1:0] op_a;
   logic [data_w-1:0] op_b;
   logic              present_a;
   logic              present_b;
   logic [data_w-1:0] alu_next;

   operand_select #(.data_w(data_w)) u_sel_a (
      .sel     (cfg.sela),
      .bus     (bus),
      .operand (op_a),
      .present (present_a)
   );

   operand_select #(.data_w(data_w)) u_sel_b (
      .sel     (cfg.selb),
      .bus     (bus),
      .operand (op_b),
      .present (present_b)
   );

   always_comb begin
      case (cfg.op)
         engine_pkg::alu_add:    alu_next = op_a + op_b;
         engine_pkg::alu_sub:    alu_next = op_a - op_b;
         engine_pkg::alu_and:    alu_next = op_a & op_b;
         engine_pkg::alu_or:     alu_next = op_a | op_b;
         engine_pkg::alu_xor:    alu_next = op_a ^ op_b;
         // signed compare for max and min
         engine_pkg::alu_max:    alu_next = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
         engine_pkg::alu_min:    alu_next = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
         engine_pkg::alu_pass_a: alu_next = op_a;
         default:                alu_next = op_a;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_reg || clear) begin
         result <= '0;
      end else if (step_en && present_a && present_b) begin
         result <= alu_next;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/engine_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module engine_ctrl #(
   parameter int data_w = 32
) (
   input  logic                    clk,
   input  logic                    rst_reg,
   input  logic                    cfg_write,
   input  logic                    cfg_addr,
   input  logic [data_w-1:0]       cfg_data,
   input  logic                    step,
   output engine_pkg::alu_cfg_t    alu_cfg,
   output engine_pkg::muladd_cfg_t muladd_cfg,
   output logic                    clear,
   output logic                    step_en,
   output logic                    out_valid
);

   localparam int alu_cfg_w    = $bits(engine_pkg::alu_cfg_t);
   localparam int muladd_cfg_w = $bits(engine_pkg::muladd_cfg_t);

   // configuration bank, low bits of the write word only
   always_ff @(posedge clk) begin
      if (rst_reg) begin
         alu_cfg    <= '0;
         muladd_cfg <= '0;
      end else if (cfg_write) begin
         if (cfg_addr == engine_pkg::cfg_addr_alu) begin
            alu_cfg <= engine_pkg::alu_cfg_t'(cfg_data[alu_cfg_w-1:0]);
         end
         if (cfg_addr == engine_pkg::cfg_addr_muladd) begin
            muladd_cfg <= engine_pkg::muladd_cfg_t'(cfg_data[muladd_cfg_w-1:0]);
         end
      end
   end

   // one clear cycle follows every write
   always_ff @(posedge clk) begin
      if (rst_reg) begin
         clear <= 1'b0;
      end else begin
         clear <= cfg_write;
      end
   end

   // step -> step_en -> out_valid
   always_ff @(posedge clk) begin
      if (rst_reg) begin
         step_en   <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         step_en   <= step;
         out_valid <= step_en;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/data_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_engine #(
   parameter int data_w = 32
) (
   input  logic              clk,
   input  logic              rst_reg,
   input  logic              cfg_write,
   input  logic              cfg_addr,
   input  logic [data_w-1:0] cfg_data,
   input  logic              step,
   input  logic [data_w-1:0] in_a,
   input  logic [data_w-1:0] in_b,
   output logic [data_w-1:0] alu_out,
   output logic [data_w-1:0] muladd_out,
   output logic              out_valid
);

   typedef struct packed {
      logic [data_w-1:0] a;
      logic [data_w-1:0] b;
   } step_in_t;

   step_in_t                                   step_in;
   logic [engine_pkg::n_slots-1:0][data_w-1:0] bus;
   engine_pkg::alu_cfg_t                       alu_cfg;
   engine_pkg::muladd_cfg_t                    muladd_cfg;
   logic                                       clear;
   logic                                       step_en;

   // inputs captured with the step strobe
   always_ff @(posedge clk) begin
      if (rst_reg) begin
         step_in <= '0;
      end else if (step) begin
         step_in <= '{a: in_a, b: in_b};
      end
   end

   // unit slots hold results of the previous step
   always_comb begin
      bus                          = '0;
      bus[engine_pkg::slot_in_a]   = step_in.a;
      bus[engine_pkg::slot_in_b]   = step_in.b;
      bus[engine_pkg::slot_alu]    = alu_out;
      bus[engine_pkg::slot_muladd] = muladd_out;
   end

   engine_ctrl #(.data_w(data_w)) u_ctrl (
      .clk        (clk),
      .rst_reg    (rst_reg),
      .cfg_write  (cfg_write),
      .cfg_addr   (cfg_addr),
      .cfg_data   (cfg_data),
      .step       (step),
      .alu_cfg    (alu_cfg),
      .muladd_cfg (muladd_cfg),
      .clear      (clear),
      .step_en    (step_en),
      .out_valid  (out_valid)
   );

   alu_unit #(.data_w(data_w)) u_alu (
      .clk     (clk),
      .rst_reg (rst_reg),
      .step_en (step_en),
      .clear   (clear),
      .cfg     (alu_cfg),
      .bus     (bus),
      .result  (alu_out)
   );

   muladd_unit #(.data_w(data_w)) u_muladd (
      .clk     (clk),
      .rst_reg (rst_reg),
      .step_en (step_en),
      .clear   (clear),
      .cfg     (muladd_cfg),
      .bus     (bus),
      .result  (muladd_out)
   );

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst_reg
);

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // reset held for two rising edges
   initial begin
      rst_reg = 1'b1;
      repeat (2) @(posedge clk);
      #2 rst_reg = 1'b0;
   end

endmodule

`default_nettype wire

// ==== sim/tb_data_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_data_engine;

   localparam int    data_w        = 32;
   localparam int    valid_timeout = 20;
   localparam int    reset_timeout = 10;
   localparam string test_file     = "sim/engine_tests.txt";

   logic              clk;
   logic              rst_reg;
   logic              cfg_write;
   logic              cfg_addr;
   logic [data_w-1:0] cfg_data;
   logic              step;
   logic [data_w-1:0] in_a;
   logic [data_w-1:0] in_b;
   logic [data_w-1:0] alu_out;
   logic [data_w-1:0] muladd_out;
   logic              out_valid;

   int          fd;
   int          fields;
   int          test_count;
   int          fail_count;
   int          waited;
   bit          aborted;
   string       line;
   string       kind;
   string       name;
   logic [31:0] f_addr;
   logic [31:0] f_data;
   logic [31:0] f_a;
   logic [31:0] f_b;
   logic [31:0] f_alu;
   logic [31:0] f_mul;

   tb_clock u_clock (
      .clk     (clk),
      .rst_reg (rst_reg)
   );

   data_engine #(.data_w(data_w)) dut (
      .clk        (clk),
      .rst_reg    (rst_reg),
      .cfg_write  (cfg_write),
      .cfg_addr   (cfg_addr),
      .cfg_data   (cfg_data),
      .step       (step),
      .in_a       (in_a),
      .in_b       (in_b),
      .alu_out    (alu_out),
      .muladd_out (muladd_out),
      .out_valid  (out_valid)
   );

   task automatic wait_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
      end
   endtask

   task automatic compare_outputs(input string tname, input logic [data_w-1:0] exp_alu,
                                  input logic [data_w-1:0] exp_mul);
      if (alu_out !== exp_alu || muladd_out !== exp_mul) begin
         $display("Fail %s: alu_out expected %h actual %h, muladd_out expected %h actual %h",
                  tname, exp_alu, alu_out, exp_mul, muladd_out);
         fail_count++;
      end else begin
         $display("pass %s", tname);
      end
   endtask

   // the clear cycle is over before the next step can start
   task automatic write_config(input logic [31:0] addr, input logic [31:0] data);
      @(posedge clk);
      #2;
      cfg_write = 1'b1;
      cfg_addr  = addr[0];
      cfg_data  = data[data_w-1:0];
      @(posedge clk);
      #2;
      cfg_write = 1'b0;
      cfg_data  = '0;
      wait_cycles(2);
   endtask

   task automatic run_step(input string tname, input logic [data_w-1:0] a,
                           input logic [data_w-1:0] b, input logic [data_w-1:0] exp_alu,
                           input logic [data_w-1:0] exp_mul);
      int gap;
      int count;
      gap = 2 + int'($urandom % 4);
      wait_cycles(gap);
      @(posedge clk);
      #2;
      step = 1'b1;
      in_a = a;
      in_b = b;
      @(posedge clk);
      #2;
      step = 1'b0;
      // out_valid is due two edges after the step is sampled
      count = 0;
      while (!out_valid && count < valid_timeout) begin
         @(posedge clk);
         #1;
         count++;
      end
      test_count++;
      if (!out_valid) begin
         $display("%s: out_valid did not arrive within %0d cycles", tname, valid_timeout);
         fail_count++;
         aborted = 1'b1;
      end else if (count != 1) begin
         $display("%s: out_valid came %0d cycles after step instead of 2", tname, count + 1);
         fail_count++;
      end else begin
         compare_outputs(tname, exp_alu, exp_mul);
      end
   endtask

   task automatic check_idle(input string tname, input logic [data_w-1:0] exp_alu,
                             input logic [data_w-1:0] exp_mul);
      bit saw_valid;
      saw_valid = 1'b0;
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
         #1;
         if (out_valid) begin
            saw_valid = 1'b1;
         end
      end
      test_count++;
      if (saw_valid) begin
         $display("%s: out_valid went high with no step pending", tname);
         fail_count++;
      end else begin
         compare_outputs(tname, exp_alu, exp_mul);
      end
   endtask

   initial begin
      cfg_write  = 1'b0;
      cfg_addr   = 1'b0;
      cfg_data   = '0;
      step       = 1'b0;
      in_a       = '0;
      in_b       = '0;
      test_count = 0;
      fail_count = 0;
      aborted    = 1'b0;
      void'($urandom(32'h51a0_3f17));

      waited = 0;
      while (rst_reg !== 1'b0 && waited < reset_timeout) begin
         @(posedge clk);
         waited++;
      end
      if (rst_reg !== 1'b0) begin
         $display("reset was never released");
         fail_count++;
         aborted = 1'b1;
      end

      fd = $fopen(test_file, "r");
      if (fd == 0) begin
         $display("cannot open %s", test_file);
         fail_count++;
         aborted = 1'b1;
      end

      // one record per line and lines starting with # are comments
      while (!aborted && $fgets(line, fd) != 0) begin
         fields = $sscanf(line, "%s", kind);
         if (fields == 1 && kind.getc(0) != "#") begin
            if (kind == "C") begin
               fields = $sscanf(line, "%s %h %h", kind, f_addr, f_data);
               if (fields == 3) begin
                  write_config(f_addr, f_data);
               end else begin
                  $display("malformed configuration record: %s", line);
                  fail_count++;
               end
            end else if (kind == "S") begin
               fields = $sscanf(line, "%s %s %h %h %h %h", kind, name, f_a, f_b, f_alu, f_mul);
               if (fields == 6) begin
                  run_step(name, f_a, f_b, f_alu, f_mul);
               end else begin
                  $display("malformed step record: %s", line);
                  fail_count++;
               end
            end else if (kind == "R") begin
               fields = $sscanf(line, "%s %s %h %h", kind, name, f_alu, f_mul);
               if (fields == 4) begin
                  check_idle(name, f_alu, f_mul);
               end else begin
                  $display("malformed idle record: %s", line);
                  fail_count++;
               end
            end else begin
               $display("unknown record kind %s in %s", kind, test_file);
               fail_count++;
            end
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end

      $display("tests run %0d, errors %0d", test_count, fail_count);
      if (fail_count == 0 && test_count > 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/engine_tests.txt ====
# C addr data : configuration write, hex
# S name in_a in_b alu_out muladd_out : step and expected outputs, hex
# R name alu_out muladd_out : idle check with no step, hex
R reset_idle 00000000 00000000
C 0 008
S alu_add 00000005 00000003 00000008 00000000
C 0 009
S alu_sub 00000005 00000007 fffffffe 00000000
C 0 00a
S alu_and f0f01234 0ff000ff 00f00034 00000000
C 0 00b
S alu_or f0f01234 0ff000ff fff012ff 00000000
C 0 00c
S alu_xor aaaa5555 ffff0000 55555555 00000000
C 0 00d
S alu_max fffffff6 00000003 00000003 00000000
S alu_max_neg fffffff6 fffffffb fffffffb 00000000
C 0 00e
S alu_min fffffff6 00000003 fffffff6 00000000
C 0 00f
S alu_pass 12345678 87654321 12345678 00000000
# mul on slots 0 and 1, result lags two steps
C 1 020
S mul_0 00000003 00000004 00000003 00000000
S mul_1 fffffffe 00000005 fffffffe 00000000
S mul_2 00010000 00010000 00010000 0000000c
S mul_3 00000007 00000008 00000007 fffffff6
S mul_4 00000000 00000000 00000000 00000000
S mul_5 00000000 00000000 00000000 00000038
# macc with reload on in_b
C 1 025
S macc_0 00000002 00000003 00000002 00000000
S macc_1 00000004 00000005 00000004 00000000
S macc_2 00000001 00000001 00000001 00000006
S macc_3 00000003 00000000 00000003 0000001a
S macc_4 00000002 00000002 00000002 0000001b
S macc_5 00000005 00000006 00000005 00000000
S macc_6 00000000 00000007 00000000 00000004
S macc_7 00000000 00000007 00000000 00000022
# alu add feeds the multiplier through slot 2
C 0 008
C 1 226
S msub_0 00000001 00000002 00000003 00000000
S msub_1 00000002 00000003 00000005 00000000
S msub_2 00000004 00000001 00000005 00000000
S msub_3 00000001 00000002 00000003 fffffff7
S msub_4 00000000 00000001 00000001 fffffff2
S msub_5 00000000 00000001 00000001 ffffffe8
C 1 227
S q16_0 00010000 00010000 00020000 00000000
S q16_1 00008000 00018000 00020000 00000000
S q16_2 ffff0000 00010000 00000000 00000000
S q16_3 fffe0000 00010000 ffff0000 00030000
S q16_4 00010000 00020000 00030000 00050000
S q16_5 00000000 00010000 00010000 00050000
S q16_6 00000000 00010000 00010000 00030000
# select code 7 holds one unit
C 1 0e5
R cleared_by_write 00000000 00000000
S hold_mul_0 00000001 00000002 00000003 00000000
S hold_mul_1 0000000a 00000014 0000001e 00000000
S hold_mul_2 00000064 00000001 00000065 00000000
C 0 1c8
C 1 020
R cleared_again 00000000 00000000
S hold_alu_0 00000003 00000004 00000000 00000000
S hold_alu_1 00000005 00000006 00000000 00000000
S hold_alu_2 00000001 00000001 00000000 0000000c
S hold_alu_3 00000001 00000001 00000000 0000001e

// ==== files.f ====
rtl/engine_pkg.sv
rtl/operand_select.sv
rtl/mul_pipe.sv
rtl/muladd_unit.sv
rtl/alu_unit.sv
rtl/engine_ctrl.sv
rtl/data_engine.sv
sim/tb_clock.sv
sim/tb_data_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the data engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_data_engine -f files.f -Mdir obj_dir -o tb_data_engine
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/tb_data_engine > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Done: no errors" sim.log; then
   exit 0
else
   exit 1
fi
